//--- rtl/mmuPkg.sv
package mmuPkg;

  ////////////////////////////////////////////////////////////////////////////
  // Address geometry
  ////////////////////////////////////////////////////////////////////////////

  localparam int VA_BITS   = 32;                    // Virtual address width
  localparam int PA_BITS   = 32;                    // Physical address width
  localparam int PAGE_BITS = 12;                    // 4 KiB pages
  localparam int VPN_BITS  = VA_BITS - PAGE_BITS;   // Virtual page number
  localparam int PPN_BITS  = PA_BITS - PAGE_BITS;   // Physical page number

  // TLB and response buffer sizing
  localparam int TLB_ENTRIES = 4;
  localparam int TLB_IDX_W   = $clog2(TLB_ENTRIES);   // Entry index / replacement pointer
  localparam int RESP_DEPTH  = 4;
  localparam int RESP_PTR_W  = $clog2(RESP_DEPTH);
  localparam int RESP_CNT_W  = $clog2(RESP_DEPTH + 1); // Count must reach RESP_DEPTH

  ////////////////////////////////////////////////////////////////////////////
  // Physical memory map
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [PA_BITS-1:0] RAM_BASE  = 32'h8000_0000;  // Main memory
  localparam logic [PA_BITS-1:0] RAM_LIMIT = 32'h8FFF_FFFF;
  localparam logic [PA_BITS-1:0] IO_BASE   = 32'h1000_0000;  // Peripherals
  localparam logic [PA_BITS-1:0] IO_LIMIT  = 32'h1000_FFFF;
  localparam logic [PA_BITS-1:0] TIM_BASE  = 32'h0200_0000;  // Tightly integrated memory
  localparam logic [PA_BITS-1:0] TIM_LIMIT = 32'h0200_FFFF;

  // Access kinds seen by the MMU
  typedef enum logic [1:0] {
    ACC_LOAD  = 2'b00,
    ACC_STORE = 2'b01,
    ACC_AMO   = 2'b10,  // Reads and writes, faults as store
    ACC_EXEC  = 2'b11   // Instruction fetch
  } accType_t;

  typedef enum logic {
    PRIV_U = 1'b0,
    PRIV_S = 1'b1
  } priv_t;

  // Leaf PTE permission bits
  typedef struct packed {
    logic r;
    logic w;
    logic x;
    logic u;  // Page reachable from user mode
  } perm_t;

  // One translation result, as queued in the response FIFO
  typedef struct packed {
    logic [PA_BITS-1:0] pAdr;
    logic tlbMiss;
    logic cacheable;
    logic idempotent;
    logic selTim;
    logic instrAccessFault;
    logic loadAccessFault;
    logic storeAmoAccessFault;
    logic instrPageFault;
    logic loadPageFault;
    logic storeAmoPageFault;
    logic loadMisaligned;
    logic storeAmoMisaligned;
  } mmuResp_t;

  localparam int RESP_W = $bits(mmuResp_t);

endpackage

//--- rtl/tlb.sv
`timescale 1ns/10ps

module tlb import mmuPkg::*; (
  input  logic                clk,
  input  logic                rstN,
  input  logic                tlbWrite,    // Fill one entry this cycle
  input  logic                tlbFlush,    // Invalidate all entries
  input  logic [VPN_BITS-1:0] tlbVpn,
  input  logic [PPN_BITS-1:0] tlbPpn,
  input  perm_t               tlbPerm,
  input  logic [VPN_BITS-1:0] vpn,         // Lookup page number
  input  accType_t            accType,
  input  priv_t               privMode,
  input  logic                statusSum,   // S-mode may touch user pages
  input  logic                statusMxr,   // Executable pages readable
  output logic                hit,
  output logic [PPN_BITS-1:0] ppn,
  output logic                pageFault
);

  logic [TLB_ENTRIES-1:0] valid;
  logic [VPN_BITS-1:0]    vpnArr  [TLB_ENTRIES];
  logic [PPN_BITS-1:0]    ppnArr  [TLB_ENTRIES];
  perm_t                  permArr [TLB_ENTRIES];
  logic [TLB_ENTRIES-1:0] hitVec;        // One-hot match vector
  perm_t                  hitPerm;
  logic [TLB_IDX_W-1:0]   rrPtr;         // Round-robin victim
  logic [TLB_IDX_W-1:0]   matchIdx, freeIdx, wrIdx;
  logic                   matchFound, freeFound;
  logic                   readOk, permFault;

  ////////////////////////////////////////////////////////////////////////////
  // Fill path
  ////////////////////////////////////////////////////////////////////////////

  // Prefer an existing mapping, then the lowest free slot, then the victim
  always_comb begin
    matchFound = 1'b0;
    matchIdx   = '0;
    freeFound  = 1'b0;
    freeIdx    = '0;
    for (int i = 0; i < TLB_ENTRIES; i++) begin
      if (!matchFound && valid[i] && vpnArr[i] == tlbVpn) begin
        matchFound = 1'b1;
        matchIdx   = TLB_IDX_W'(i);
      end
      if (!freeFound && !valid[i]) begin
        freeFound = 1'b1;
        freeIdx   = TLB_IDX_W'(i);
      end
    end
    wrIdx = matchFound ? matchIdx : (freeFound ? freeIdx : rrPtr);
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      valid <= '0;
      rrPtr <= '0;
    end else begin
      if (tlbFlush) valid <= '0;                    // Flush wins over a write
      else if (tlbWrite) valid[wrIdx] <= 1'b1;
      if (tlbWrite && !matchFound && !freeFound) rrPtr <= rrPtr + 1'b1;  // Replacement used
    end
  end

  always_ff @(posedge clk) begin
    if (tlbWrite) begin
      vpnArr[wrIdx]  <= tlbVpn;
      ppnArr[wrIdx]  <= tlbPpn;
      permArr[wrIdx] <= tlbPerm;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Lookup and permission check
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    ppn     = '0;
    hitPerm = '0;
    for (int i = 0; i < TLB_ENTRIES; i++) begin
      hitVec[i] = valid[i] && (vpnArr[i] == vpn);
      if (hitVec[i]) begin
        ppn     = ppn | ppnArr[i];                   // AND-OR mux, hits are one-hot
        hitPerm = perm_t'(hitPerm | permArr[i]);
      end
    end
  end

  assign hit    = |hitVec;
  assign readOk = hitPerm.r | (statusMxr & hitPerm.x);

  always_comb begin
    permFault = 1'b0;
    if ((accType == ACC_LOAD || accType == ACC_AMO) && !readOk) permFault = 1'b1;
    if ((accType == ACC_STORE || accType == ACC_AMO) && !hitPerm.w) permFault = 1'b1;
    if (accType == ACC_EXEC && !hitPerm.x) permFault = 1'b1;
    if (privMode == PRIV_U && !hitPerm.u) permFault = 1'b1;     // Supervisor-only page
    if (privMode == PRIV_S && hitPerm.u && !statusSum) permFault = 1'b1;
  end

  assign pageFault = hit & permFault;  // Misses never fault here

  // Fill path keeps VPNs unique, so a lookup never matches twice
  assert property (@(posedge clk) disable iff (!rstN) $onehot0(hitVec));

endmodule

//--- rtl/pmaChecker.sv
`timescale 1ns/10ps

module pmaChecker import mmuPkg::*; (
  input  logic [PA_BITS-1:0] pAdr,
  input  accType_t           accType,
  output logic               cacheable,
  output logic               idempotent,
  output logic               selTim,       // Route to the TIM instead of the bus
  output logic               accessFault
);

  logic inRam, inIo, inTim;

  // Region decode, bounds are inclusive
  assign inRam = (pAdr >= RAM_BASE) && (pAdr <= RAM_LIMIT);
  assign inIo  = (pAdr >= IO_BASE)  && (pAdr <= IO_LIMIT);
  assign inTim = (pAdr >= TIM_BASE) && (pAdr <= TIM_LIMIT);

  assign cacheable  = inRam;
  assign idempotent = inRam | inTim;  // IO reads may have side effects
  assign selTim     = inTim;

  always_comb begin
    accessFault = 1'b0;
    if (inIo) begin
      // No fetch or atomics from peripherals
      accessFault = (accType == ACC_EXEC) || (accType == ACC_AMO);
    end else if (!inRam && !inTim) begin
      accessFault = 1'b1;             // Unmapped space
    end
  end

endmodule

//--- rtl/mmu.sv
`timescale 1ns/10ps

module mmu import mmuPkg::*; (
  input  logic                clk,
  input  logic                rstN,
  input  logic [VA_BITS-1:0]  vAdr,
  input  logic [1:0]          size,         // 0 byte, 1 half, 2 word, 3 double
  input  accType_t            accType,
  input  logic                translateOn,  // satp mode non-bare
  input  priv_t               privMode,
  input  logic                statusSum,
  input  logic                statusMxr,
  input  logic                tlbWrite,
  input  logic                tlbFlush,
  input  logic [VPN_BITS-1:0] tlbVpn,
  input  logic [PPN_BITS-1:0] tlbPpn,
  input  perm_t               tlbPerm,
  output mmuResp_t            respWrData
);

  logic [PPN_BITS-1:0] tlbPpnOut;
  logic [PA_BITS-1:0]  pAdr;
  logic                tlbHit, tlbPageFault;
  logic                tlbMiss;
  logic                pmaFault, cacheable, idempotent, selTim;
  logic                misaligned;
  logic                accFault, pgFault;     // Masked, not yet split by kind
  logic                isExec, isLoad, isStoreAmo;

  tlb tlb_i (
    .clk, .rstN,
    .tlbWrite, .tlbFlush, .tlbVpn, .tlbPpn, .tlbPerm,
    .vpn(vAdr[VA_BITS-1:PAGE_BITS]),
    .accType, .privMode, .statusSum, .statusMxr,
    .hit(tlbHit), .ppn(tlbPpnOut), .pageFault(tlbPageFault)
  );

  // Offset untouched, page number from TLB only when translating
  assign pAdr[PAGE_BITS-1:0]       = vAdr[PAGE_BITS-1:0];
  assign pAdr[PA_BITS-1:PAGE_BITS] = translateOn ? tlbPpnOut : vAdr[PA_BITS-1:PAGE_BITS];

  pmaChecker pmaChecker_i (
    .pAdr, .accType,
    .cacheable, .idempotent, .selTim,
    .accessFault(pmaFault)
  );

  assign tlbMiss = translateOn & ~tlbHit;
  assign accFault = pmaFault & ~tlbMiss;                      // PMA result meaningless on miss
  assign pgFault  = tlbPageFault & translateOn;               // Stale hits ignored in bare mode

  ////////////////////////////////////////////////////////////////////////////
  // Alignment and fault kinds
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (size)
      2'b00:   misaligned = 1'b0;
      2'b01:   misaligned = vAdr[0];
      2'b10:   misaligned = |vAdr[1:0];
      default: misaligned = |vAdr[2:0];
    endcase
  end

  assign isExec     = (accType == ACC_EXEC);
  assign isLoad     = (accType == ACC_LOAD);
  assign isStoreAmo = (accType == ACC_STORE) || (accType == ACC_AMO);  // AMO reports as store

  always_comb begin
    respWrData                     = '0;
    respWrData.pAdr                = pAdr;
    respWrData.tlbMiss             = tlbMiss;
    respWrData.cacheable           = cacheable;
    respWrData.idempotent          = idempotent;
    respWrData.selTim              = selTim;
    respWrData.instrAccessFault    = accFault & isExec;
    respWrData.loadAccessFault     = accFault & isLoad;
    respWrData.storeAmoAccessFault = accFault & isStoreAmo;
    respWrData.instrPageFault      = pgFault & isExec;
    respWrData.loadPageFault       = pgFault & isLoad;
    respWrData.storeAmoPageFault   = pgFault & isStoreAmo;
    respWrData.loadMisaligned      = misaligned & isLoad;
    respWrData.storeAmoMisaligned  = misaligned & isStoreAmo;
  end

endmodule

//--- rtl/respFifo.sv
`timescale 1ns/10ps

module respFifo import mmuPkg::*; #(
  parameter int WIDTH = RESP_W
) (
  input  logic             clk,
  input  logic             rstN,
  input  logic             wrValid,
  input  logic [WIDTH-1:0] wrData,
  output logic             wrReady,
  output logic             rdValid,
  output logic [WIDTH-1:0] rdData,
  input  logic             rdReady
);

  logic [WIDTH-1:0]      mem [RESP_DEPTH];
  logic [RESP_PTR_W-1:0] wrPtr, rdPtr;
  logic [RESP_CNT_W-1:0] count;
  logic                  wrEn, rdEn;

  assign wrReady = (count != RESP_CNT_W'(RESP_DEPTH));  // Not full
  assign rdValid = (count != '0);
  assign rdData  = mem[rdPtr];
  assign wrEn    = wrValid & wrReady;
  assign rdEn    = rdValid & rdReady;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (wrEn) wrPtr <= (wrPtr == RESP_PTR_W'(RESP_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
      if (rdEn) rdPtr <= (rdPtr == RESP_PTR_W'(RESP_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
      if (wrEn && !rdEn) count <= count + 1'b1;
      else if (rdEn && !wrEn) count <= count - 1'b1;  // Both at once keeps the level
    end
  end

  always_ff @(posedge clk) begin
    if (wrEn) mem[wrPtr] <= wrData;
  end

  // Level counter overflow or underflow pushes it past the depth
  assert property (@(posedge clk) disable iff (!rstN)
    count <= RESP_CNT_W'(RESP_DEPTH));
  // Pointers only meet when empty or full
  assert property (@(posedge clk) disable iff (!rstN)
    (wrPtr == rdPtr) |-> (count == '0 || count == RESP_CNT_W'(RESP_DEPTH)));

endmodule

//--- rtl/mmuTop.sv
`timescale 1ns/10ps

module mmuTop import mmuPkg::*; (
  input  logic                clk,
  input  logic                rstN,
  // Request port
  input  logic                reqValid,
  output logic                reqReady,
  input  logic [VA_BITS-1:0]  vAdr,
  input  logic [1:0]          size,
  input  accType_t            accType,
  // Configuration, sampled with each request
  input  logic                translateOn,
  input  priv_t               privMode,
  input  logic                statusSum,
  input  logic                statusMxr,
  // TLB fill from the walker side
  input  logic                tlbWrite,
  input  logic                tlbFlush,
  input  logic [VPN_BITS-1:0] tlbVpn,
  input  logic [PPN_BITS-1:0] tlbPpn,
  input  perm_t               tlbPerm,
  // Response port
  output logic                respValid,
  output mmuResp_t            resp,
  input  logic                respReady
);

  mmuResp_t respWrData;
  logic     wrReady;

  mmu mmu_i (
    .clk, .rstN,
    .vAdr, .size, .accType,
    .translateOn, .privMode, .statusSum, .statusMxr,
    .tlbWrite, .tlbFlush, .tlbVpn, .tlbPpn, .tlbPerm,
    .respWrData
  );

  // Translation is same-cycle, so the request valid is the FIFO write valid
  respFifo #(.WIDTH(RESP_W)) respFifo_i (
    .clk, .rstN,
    .wrValid(reqValid), .wrData(respWrData), .wrReady,
    .rdValid(respValid), .rdData(resp), .rdReady(respReady)
  );

  assign reqReady = wrReady;  // FIFO space is the only back-pressure

endmodule

//--- sim/clockGen.sv
`timescale 1ns/10ps

module clockGen (
  output logic clk,
  output logic rstN
);

  localparam int CLK_PERIOD   = 20;  // ns
  localparam int RESET_CYCLES = 16;

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Release a little after the edge, like all other testbench drives
  initial begin
    rstN = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #2 rstN = 1'b1;
  end

endmodule

//--- sim/mmuTb.sv
`timescale 1ns/10ps

module mmuTb import mmuPkg::*; ();

  localparam string DATA_FILE      = "sim/mmuTestdata.txt";
  localparam int    CYCLES_PER_CMD = 40;              // Watchdog budget per data line
  localparam int    FLAG_W         = RESP_W - PA_BITS; // Everything after pAdr

  logic                clk, rstN;
  logic                reqValid, reqReady;
  logic [VA_BITS-1:0]  vAdr;
  logic [1:0]          size;
  accType_t            accType;
  logic                translateOn;
  priv_t               privMode;
  logic                statusSum, statusMxr;
  logic                tlbWrite, tlbFlush;
  logic [VPN_BITS-1:0] tlbVpn;
  logic [PPN_BITS-1:0] tlbPpn;
  perm_t               tlbPerm;
  logic                respValid, respReady;
  mmuResp_t            resp;

  string    cmds[$];          // Data lines without comments
  int       nCmds = 0;
  string    curName;          // Request currently on the port
  mmuResp_t curExp;
  string    nameQ[$];         // In flight, oldest first
  mmuResp_t expQ[$];
  int       cycle;            // Clock count, owned by the ready driver
  int       holdEnd;          // respReady forced low until this cycle
  int       nPass = 0;
  int       nFail = 0;
  int       nOther = 0;
  int       nReq = 0;
  bit       sawFull = 1'b0;

  clockGen clockGen_i (.clk, .rstN);

  mmuTop dut_i (
    .clk, .rstN,
    .reqValid, .reqReady, .vAdr, .size, .accType,
    .translateOn, .privMode, .statusSum, .statusMxr,
    .tlbWrite, .tlbFlush, .tlbVpn, .tlbPpn, .tlbPerm,
    .respValid, .resp, .respReady
  );

  ////////////////////////////////////////////////////////////////////////////
  // Response side
  ////////////////////////////////////////////////////////////////////////////

  task automatic clearStrobes();
    reqValid = 1'b0;
    tlbWrite = 1'b0;
    tlbFlush = 1'b0;
  endtask

  // Pop the oldest expectation and compare it with the word on resp
  task automatic checkResponse();
    string    name;
    mmuResp_t exp;
    bit       ok;
    if (expQ.size() == 0) begin
      $display("Response arrived with no request outstanding, pAdr %h", resp.pAdr);
      nOther++;
    end else begin
      name = nameQ.pop_front();
      exp  = expQ.pop_front();
      ok   = (resp === exp);
      assert (ok) else begin
        $display("Error %s: expected %h/%b actual %h/%b", name,
                 exp.pAdr, exp[FLAG_W-1:0], resp.pAdr, resp[FLAG_W-1:0]);
        nFail++;
      end
      if (ok) begin
        $display("%-14s passed", name);
        nPass++;
      end
    end
  endtask

  // Random read pressure, with a forced-low stretch on request
  initial begin : readyDriver
    bit hold;
    respReady = 1'b0;
    cycle     = 0;
    void'($urandom(85));
    forever begin
      @(posedge clk);
      cycle++;
      hold = (cycle < holdEnd);  // holdEnd is stable at the edge
      #2;
      respReady = hold ? 1'b0 : (($urandom % 4) != 0);
    end
  end

  // Mid-cycle monitor, handshakes complete at the next rising edge
  always @(negedge clk) begin
    if (rstN) begin
      assert (reqReady == (expQ.size() != RESP_DEPTH)) else begin
        $display("Request ready is %b with %0d responses in flight", reqReady, expQ.size());
        nOther++;
      end
      assert (respValid == (expQ.size() != 0)) else begin
        $display("Response valid is %b with %0d responses in flight", respValid, expQ.size());
        nOther++;
      end
      if (expQ.size() == RESP_DEPTH) sawFull = 1'b1;
      if (respValid && respReady) checkResponse();
      if (reqValid && reqReady) begin
        nameQ.push_back(curName);
        expQ.push_back(curExp);
        nReq++;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus from the data file
  ////////////////////////////////////////////////////////////////////////////

  initial begin : mainSeq
    int                fd;
    string             line;
    string             name;
    byte               op;
    int                n, a, b, c, d;
    logic [31:0]       x, y, expAdr;
    logic [FLAG_W-1:0] expFlags;
    logic [3:0]        permBits;
    bit                fileOk;
    bit                bad;
    int                badLines;
    int                endErrors;
    fileOk      = 1'b0;
    badLines    = 0;
    endErrors   = 0;
    holdEnd     = 0;
    clearStrobes();
    vAdr        = '0;
    size        = '0;
    accType     = ACC_LOAD;
    translateOn = 1'b0;
    privMode    = PRIV_S;
    statusSum   = 1'b0;
    statusMxr   = 1'b0;
    tlbVpn      = '0;
    tlbPpn      = '0;
    tlbPerm     = '0;

    fd = $fopen(DATA_FILE, "r");
    if (fd != 0) begin
      fileOk = 1'b1;
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 0 && line.getc(0) != "#" && line.getc(0) != "\n") cmds.push_back(line);
      end
      $fclose(fd);
    end
    nCmds = cmds.size();               // Arms the watchdog

    if (!fileOk) begin
      $display("Cannot open stimulus file %s", DATA_FILE);
    end else begin
      wait (rstN === 1'b1);
      foreach (cmds[i]) begin
        @(posedge clk);
        #2;
        clearStrobes();                // Strobes last one cycle
        line = cmds[i];
        op   = line.getc(0);
        bad  = 1'b0;
        case (op)
          "W": begin                   // TLB fill
            n = $sscanf(line, "W %h %h %b", x, y, permBits);
            bad = (n != 3);
            tlbVpn   = x[VPN_BITS-1:0];
            tlbPpn   = y[PPN_BITS-1:0];
            tlbPerm  = perm_t'(permBits);
            tlbWrite = !bad;
          end
          "F": tlbFlush = 1'b1;
          "C": begin                   // translateOn privMode sum mxr
            n = $sscanf(line, "C %d %d %d %d", a, b, c, d);
            bad = (n != 4);
            translateOn = a[0];
            privMode    = priv_t'(b[0]);
            statusSum   = c[0];
            statusMxr   = d[0];
          end
          "H": begin
            n = $sscanf(line, "H %d", a);
            bad = (n != 1);
            holdEnd = cycle + a;
          end
          "R": begin
            n = $sscanf(line, "R %s %h %d %d %h %b", name, x, a, b, expAdr, expFlags);
            bad = (n != 6);
            if (!bad) begin
              curName  = name;
              curExp   = mmuResp_t'({expAdr, expFlags});
              vAdr     = x;
              size     = a[1:0];
              accType  = accType_t'(b[1:0]);
              reqValid = 1'b1;
              @(negedge clk);
              while (!reqReady) @(negedge clk);  // Accepted at the coming edge
            end
          end
          default: bad = 1'b1;
        endcase
        if (bad) begin
          $display("Malformed stimulus line: %s", line);
          badLines++;
        end
      end
      @(posedge clk);
      #2;
      clearStrobes();
      while (expQ.size() != 0) @(negedge clk);  // Drain under random ready

      assert (sawFull) else begin
        $display("Response FIFO never filled during the back-pressure stretch");
        endErrors++;
      end
      assert (badLines == 0) else begin
        $display("%0d stimulus lines could not be parsed", badLines);
        endErrors++;
      end
    end

    $display("Tests %0d, passed %0d, failed %0d, other errors %0d",
             nReq, nPass, nFail, nOther + endErrors);
    if (fileOk && nReq > 0 && nFail == 0 && nOther == 0 && endErrors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // Whole run bounded by the length of the data file
  initial begin : watchdog
    wait (nCmds > 0);
    repeat (nCmds * CYCLES_PER_CMD) @(posedge clk);
    $display("Timeout: run still busy after %0d clock cycles", nCmds * CYCLES_PER_CMD);
    $display("Test FAILED");
    $finish;
  end

endmodule

//--- sim/mmuTestdata.txt
# W vpn ppn perm(rwxu) | F | C translateOn priv(0 U,1 S) sum mxr | H cycles (respReady low)
# R name vAdr size acc(0 ld,1 st,2 amo,3 ex) pAdr flags(miss C I T iA lA sA iP lP sP lMis sMis)
R bare_ram_ld 80001234 2 0 80001234 011000000000
R bare_tim_st 02000010 3 1 02000010 001100000000
R bare_io_ld 10000004 2 0 10000004 000000000000
R bare_io_amo 10000008 2 2 10000008 000000100000
R bare_io_ex 1000000c 2 3 1000000c 000010000000
R bare_unmap_ld 00000100 2 0 00000100 000001000000
R bare_mis_half 80000001 1 0 80000001 011000000010
R bare_mis_amo 80000006 2 2 80000006 011000000001
R bare_mis_dbl 80000004 3 1 80000004 011000000001
R bare_byte_odd 80000003 0 0 80000003 011000000000
C 1 1 0 0
W 00040 80010 1110
W 00041 10000 1100
R tr_hit_ld 00040abc 0 0 80010abc 011000000000
R tr_io_st 00041010 2 1 10000010 000000000000
R tr_io_amo 00041018 2 2 10000018 000000100000
W 00042 80020 0010
R pf_ld_nor 00042100 2 0 80020100 011000001000
R pf_st_now 00042104 2 1 80020104 011000000100
R ex_ok 00042108 2 3 80020108 011000000000
C 1 1 0 1
R mxr_ld 0004210c 2 0 8002010c 011000000000
R pf_amo 00042110 2 2 80020110 011000000100
W 00043 80030 1001
R pf_s_user 00043000 2 0 80030000 011000001000
C 1 1 1 0
R sum_ld 00043004 2 0 80030004 011000000000
R pf_s_user_x 00043008 2 3 80030008 011000010000
C 1 0 0 0
R u_ld 0004300c 2 0 8003000c 011000000000
R pf_u_st 00043010 2 1 80030010 011000000100
R pf_u_sup 00040000 2 0 80010000 011000001000
C 1 1 0 0
# Table is full, this fill replaces the oldest entry (vpn 00040)
W 00044 80040 1000
R evict_miss 00040004 2 0 00000004 100000000000
R new_ld 00044040 2 0 80040040 011000000000
R remap_mis_st 00041021 1 1 10000021 000000000001
F
R flush_miss 00044040 2 0 00000040 100000000000
C 0 1 0 0
H 30
R bp_0 80000000 2 0 80000000 011000000000
R bp_1 80000004 2 1 80000004 011000000000
R bp_2 02000008 3 0 02000008 001100000000
R bp_3 10000000 2 0 10000000 000000000000
R bp_4 8000000c 2 0 8000000c 011000000000
R bp_5 00000010 2 2 00000010 000000100000

//--- flist.f
rtl/mmuPkg.sv
rtl/tlb.sv
rtl/pmaChecker.sv
rtl/mmu.sv
rtl/respFifo.sv
rtl/mmuTop.sv
sim/clockGen.sv
sim/mmuTb.sv

//--- Makefile
# Verilator flow for the MMU testbench, run from the project root

VERILATOR ?= verilator
TOP       ?= mmuTb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Test OK

SRCS := $(shell cat $(FLIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

$(OBJ_DIR)/V$(TOP): $(SRCS) $(FLIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# The log decides, the simulator exit status alone does not
sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
